// ==== project.f ====
+incdir+tests
src/mips_pkg.sv
src/mips_bypass_if.sv
src/mips_fetch.sv
src/mips_decode.sv
src/mips_execute.sv
src/mips_memory.sv
src/mips_core.sv
tests/tb_mips_core.sv

// ==== src/mips_bypass_if.sv ====
interface mips_bypass_if;

    // EX/MEM stage
    logic                            ex_reg_write;
    logic [mips_pkg::REG_ADDR_W-1:0] ex_dst;
    logic [mips_pkg::DATA_W-1:0]     ex_result;

    // MEM/WB stage, final writeback value
    logic                            wb_reg_write;
    logic [mips_pkg::REG_ADDR_W-1:0] wb_dst;
    logic [mips_pkg::DATA_W-1:0]     wb_data;

    modport producer (
        output ex_reg_write, ex_dst, ex_result,
        output wb_reg_write, wb_dst, wb_data
    );

    modport consumer (
        input ex_reg_write, ex_dst, ex_result,
        input wb_reg_write, wb_dst, wb_data
    );

endinterface

// ==== src/mips_core.sv ====
module mips_core #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 16
) (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  logic                            i_run,
    input  logic                            i_imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0]   i_imem_addr,
    input  logic [mips_pkg::DATA_W-1:0]     i_imem_data,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_dbg_reg_addr,
    input  logic [$clog2(DMEM_DEPTH)-1:0]   i_dbg_mem_addr,
    output logic [mips_pkg::DATA_W-1:0]     o_pc,
    output logic [mips_pkg::DATA_W-1:0]     o_dbg_reg_data,
    output logic [mips_pkg::DATA_W-1:0]     o_dbg_mem_data,
    output logic                            o_halt
);

    mips_pkg::ifid_t  ifid;
    mips_pkg::idex_t  idex;
    mips_pkg::exmem_t exmem;
    logic             stall;

    mips_bypass_if bypass ();

    mips_fetch #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) mips_fetch_inst (
        .i_clk       (i_clk),
        .i_arst_n    (i_arst_n),
        .i_run       (i_run),
        .i_stall     (stall),
        .i_imem_we   (i_imem_we),
        .i_imem_addr (i_imem_addr),
        .i_imem_data (i_imem_data),
        .o_ifid      (ifid),
        .o_pc        (o_pc)
    );

    mips_decode mips_decode_inst (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_ifid         (ifid),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .bypass         (bypass.consumer),
        .o_idex         (idex),
        .o_stall        (stall),
        .o_dbg_reg_data (o_dbg_reg_data)
    );

    mips_execute mips_execute_inst (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_idex    (idex),
        .bypass_rd (bypass.consumer),
        .bypass_wr (bypass.producer),
        .o_exmem   (exmem)
    );

    mips_memory #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) mips_memory_inst (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_exmem        (exmem),
        .i_dbg_mem_addr (i_dbg_mem_addr),
        .bypass         (bypass.producer),
        .o_dbg_mem_data (o_dbg_mem_data),
        .o_halt         (o_halt)
    );

endmodule

// ==== src/mips_decode.sv ====
module mips_decode (
    input  logic                            i_clk,
    input  logic                            i_arst_n,
    input  mips_pkg::ifid_t                 i_ifid,
    input  logic [mips_pkg::REG_ADDR_W-1:0] i_dbg_reg_addr,
    mips_bypass_if.consumer                 bypass,
    output mips_pkg::idex_t                 o_idex,
    output logic                            o_stall,
    output logic [mips_pkg::DATA_W-1:0]     o_dbg_reg_data
);

    localparam int RS_LSB = mips_pkg::IMM_W + mips_pkg::REG_ADDR_W;
    localparam int RT_LSB = mips_pkg::IMM_W;
    localparam int RD_LSB = mips_pkg::IMM_W - mips_pkg::REG_ADDR_W;

    logic [mips_pkg::DATA_W-1:0]     regs [2**mips_pkg::REG_ADDR_W];
    logic [mips_pkg::OPCODE_W-1:0]   opcode;
    logic [mips_pkg::REG_ADDR_W-1:0] rs;
    logic [mips_pkg::REG_ADDR_W-1:0] rt;
    logic [mips_pkg::REG_ADDR_W-1:0] rd;
    logic [mips_pkg::IMM_W-1:0]      imm;
    logic [mips_pkg::FUNCT_W-1:0]    funct;
    logic [mips_pkg::DATA_W-1:0]     imm_ext;
    logic [mips_pkg::DATA_W-1:0]     rs_val;
    logic [mips_pkg::DATA_W-1:0]     rt_val;
    logic                            load_use;
    mips_pkg::ctrl_t                 ctrl;
    mips_pkg::idex_t                 idex_q;

    // Instruction fields
    assign opcode = i_ifid.instr[mips_pkg::DATA_W-1 -: mips_pkg::OPCODE_W];
    assign rs     = i_ifid.instr[RS_LSB +: mips_pkg::REG_ADDR_W];
    assign rt     = i_ifid.instr[RT_LSB +: mips_pkg::REG_ADDR_W];
    assign rd     = i_ifid.instr[RD_LSB +: mips_pkg::REG_ADDR_W];
    assign imm    = i_ifid.instr[mips_pkg::IMM_W-1:0];
    assign funct  = i_ifid.instr[mips_pkg::FUNCT_W-1:0];

    assign imm_ext = {{(mips_pkg::DATA_W - mips_pkg::IMM_W){imm[mips_pkg::IMM_W-1]}}, imm};

    always_comb begin
        ctrl = '0;
        case (opcode)
            mips_pkg::OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                ctrl.alu_class = mips_pkg::CLS_FUNCT;
            end
            mips_pkg::OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_class = mips_pkg::CLS_ADD;
            end
            mips_pkg::OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_class  = mips_pkg::CLS_ADD;
            end
            mips_pkg::OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_class = mips_pkg::CLS_ADD;
            end
            mips_pkg::OP_HALT: begin
                ctrl.halt = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // Register file, r0 is never written
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < 2**mips_pkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (bypass.wb_reg_write && bypass.wb_dst != '0) begin
            regs[bypass.wb_dst] <= bypass.wb_data;
        end
    end

    // Same-cycle writeback is visible to the read
    assign rs_val = (bypass.wb_reg_write && bypass.wb_dst == rs && rs != '0) ?
                    bypass.wb_data : regs[rs];
    assign rt_val = (bypass.wb_reg_write && bypass.wb_dst == rt && rt != '0) ?
                    bypass.wb_data : regs[rt];

    assign o_dbg_reg_data = regs[i_dbg_reg_addr];

    // Load in EX whose result is needed here
    assign load_use = idex_q.ctrl.mem_read && idex_q.rt != '0 &&
                      (idex_q.rt == rs || idex_q.rt == rt);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            idex_q <= '0;
        end else if (load_use) begin
            idex_q <= '0;
        end else begin
            idex_q.ctrl   <= ctrl;
            idex_q.rs_val <= rs_val;
            idex_q.rt_val <= rt_val;
            idex_q.imm    <= imm_ext;
            idex_q.rs     <= rs;
            idex_q.rt     <= rt;
            idex_q.rd     <= rd;
            idex_q.funct  <= funct;
        end
    end

    assign o_idex  = idex_q;
    assign o_stall = load_use;

endmodule

// ==== src/mips_execute.sv ====
module mips_execute (
    input  logic             i_clk,
    input  logic             i_arst_n,
    input  mips_pkg::idex_t  i_idex,
    mips_bypass_if.consumer  bypass_rd,
    mips_bypass_if.producer  bypass_wr,
    output mips_pkg::exmem_t o_exmem
);

    logic [mips_pkg::DATA_W-1:0] op_a;
    logic [mips_pkg::DATA_W-1:0] rt_fwd;
    logic [mips_pkg::DATA_W-1:0] op_b;
    logic [mips_pkg::DATA_W-1:0] alu_result;
    logic [mips_pkg::REG_ADDR_W-1:0] dst;
    mips_pkg::fwd_sel_e          sel_a;
    mips_pkg::fwd_sel_e          sel_b;
    mips_pkg::alu_op_e           alu_op;
    mips_pkg::exmem_t            exmem_q;

    // Newer stage wins, r0 is never forwarded
    function automatic mips_pkg::fwd_sel_e fwd_select(
        input logic [mips_pkg::REG_ADDR_W-1:0] src,
        input logic                            ex_we,
        input logic [mips_pkg::REG_ADDR_W-1:0] ex_dst,
        input logic                            wb_we,
        input logic [mips_pkg::REG_ADDR_W-1:0] wb_dst
    );
        mips_pkg::fwd_sel_e sel;
        sel = mips_pkg::FWD_REG;
        if (src != '0 && ex_we && ex_dst == src) begin
            sel = mips_pkg::FWD_EXMEM;
        end else if (src != '0 && wb_we && wb_dst == src) begin
            sel = mips_pkg::FWD_MEMWB;
        end
        return sel;
    endfunction

    function automatic logic [mips_pkg::DATA_W-1:0] fwd_mux(
        input mips_pkg::fwd_sel_e          sel,
        input logic [mips_pkg::DATA_W-1:0] reg_val,
        input logic [mips_pkg::DATA_W-1:0] ex_val,
        input logic [mips_pkg::DATA_W-1:0] wb_val
    );
        logic [mips_pkg::DATA_W-1:0] val;
        case (sel)
            mips_pkg::FWD_EXMEM: val = ex_val;
            mips_pkg::FWD_MEMWB: val = wb_val;
            default:             val = reg_val;
        endcase
        return val;
    endfunction

    assign sel_a = fwd_select(i_idex.rs, bypass_rd.ex_reg_write, bypass_rd.ex_dst,
                              bypass_rd.wb_reg_write, bypass_rd.wb_dst);
    assign sel_b = fwd_select(i_idex.rt, bypass_rd.ex_reg_write, bypass_rd.ex_dst,
                              bypass_rd.wb_reg_write, bypass_rd.wb_dst);

    assign op_a   = fwd_mux(sel_a, i_idex.rs_val, bypass_rd.ex_result, bypass_rd.wb_data);
    assign rt_fwd = fwd_mux(sel_b, i_idex.rt_val, bypass_rd.ex_result, bypass_rd.wb_data);
    assign op_b   = i_idex.ctrl.alu_src ? i_idex.imm : rt_fwd;

    // ALU control
    always_comb begin
        case (i_idex.ctrl.alu_class)
            mips_pkg::CLS_SUB: alu_op = mips_pkg::ALU_SUB;
            mips_pkg::CLS_FUNCT: begin
                case (i_idex.funct)
                    mips_pkg::FN_SUB: alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND: alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:  alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT: alu_op = mips_pkg::ALU_SLT;
                    default:          alu_op = mips_pkg::ALU_ADD;
                endcase
            end
            default: alu_op = mips_pkg::ALU_ADD;
        endcase
    end

    always_comb begin
        case (alu_op)
            mips_pkg::ALU_SUB: alu_result = op_a - op_b;
            mips_pkg::ALU_AND: alu_result = op_a & op_b;
            mips_pkg::ALU_OR:  alu_result = op_a | op_b;
            // Signed compare
            mips_pkg::ALU_SLT: alu_result = {{(mips_pkg::DATA_W-1){1'b0}},
                                             $signed(op_a) < $signed(op_b)};
            default:           alu_result = op_a + op_b;
        endcase
    end

    assign dst = i_idex.ctrl.reg_dst ? i_idex.rd : i_idex.rt;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            exmem_q <= '0;
        end else begin
            exmem_q.reg_write  <= i_idex.ctrl.reg_write;
            exmem_q.mem_read   <= i_idex.ctrl.mem_read;
            exmem_q.mem_write  <= i_idex.ctrl.mem_write;
            exmem_q.mem_to_reg <= i_idex.ctrl.mem_to_reg;
            exmem_q.halt       <= i_idex.ctrl.halt;
            exmem_q.alu_result <= alu_result;
            exmem_q.store_data <= rt_fwd;
            exmem_q.dst        <= dst;
        end
    end

    assign bypass_wr.ex_reg_write = exmem_q.reg_write;
    assign bypass_wr.ex_dst       = exmem_q.dst;
    assign bypass_wr.ex_result    = exmem_q.alu_result;

    assign o_exmem = exmem_q;

endmodule

// ==== src/mips_fetch.sv ====
module mips_fetch #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  logic                          i_run,
    input  logic                          i_stall,
    input  logic                          i_imem_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] i_imem_addr,
    input  logic [mips_pkg::DATA_W-1:0]   i_imem_data,
    output mips_pkg::ifid_t               o_ifid,
    output logic [mips_pkg::DATA_W-1:0]   o_pc
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);

    logic [mips_pkg::DATA_W-1:0] imem [IMEM_DEPTH];
    logic [mips_pkg::DATA_W-1:0] pc_q;
    logic [mips_pkg::DATA_W-1:0] pc_next;
    logic [mips_pkg::DATA_W-1:0] instr;
    logic                        halted_q;
    mips_pkg::ifid_t             ifid_q;

    // Program load port
    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;
        end
    end

    assign instr   = imem[pc_q[IMEM_AW+1:2]];
    assign pc_next = pc_q + mips_pkg::DATA_W'(4);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q     <= '0;
            halted_q <= 1'b0;
            ifid_q   <= '0;
        end else if (!i_stall) begin
            if (i_run && !halted_q) begin
                pc_q         <= pc_next;
                ifid_q.instr <= instr;
                ifid_q.pc4   <= pc_next;
                // Nothing is fetched past a halt
                halted_q     <= (instr[mips_pkg::DATA_W-1 -: mips_pkg::OPCODE_W]
                                 == mips_pkg::OP_HALT);
            end else begin
                ifid_q <= '0;
            end
        end
    end

    assign o_ifid = ifid_q;
    assign o_pc   = pc_q;

endmodule

// ==== src/mips_memory.sv ====
module mips_memory #(
    parameter int DMEM_DEPTH = 16
) (
    input  logic                          i_clk,
    input  logic                          i_arst_n,
    input  mips_pkg::exmem_t              i_exmem,
    input  logic [$clog2(DMEM_DEPTH)-1:0] i_dbg_mem_addr,
    mips_bypass_if.producer               bypass,
    output logic [mips_pkg::DATA_W-1:0]   o_dbg_mem_data,
    output logic                          o_halt
);

    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    logic [mips_pkg::DATA_W-1:0] dmem [DMEM_DEPTH];
    logic [DMEM_AW-1:0]          word_idx;
    logic [mips_pkg::DATA_W-1:0] load_data;
    logic [mips_pkg::DATA_W-1:0] wb_data;
    logic                        halt_q;
    mips_pkg::memwb_t            memwb_q;

    // Byte address to word index, wrapping at the depth
    assign word_idx  = i_exmem.alu_result[DMEM_AW+1:2];
    assign load_data = i_exmem.mem_read ? dmem[word_idx] : '0;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (i_exmem.mem_write) begin
            dmem[word_idx] <= i_exmem.store_data;
        end
    end

    assign o_dbg_mem_data = dmem[i_dbg_mem_addr];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            memwb_q <= '0;
            halt_q  <= 1'b0;
        end else begin
            memwb_q.reg_write  <= i_exmem.reg_write;
            memwb_q.mem_to_reg <= i_exmem.mem_to_reg;
            memwb_q.halt       <= i_exmem.halt;
            memwb_q.alu_result <= i_exmem.alu_result;
            memwb_q.load_data  <= load_data;
            memwb_q.dst        <= i_exmem.dst;
            // Sticky until reset
            halt_q             <= halt_q | memwb_q.halt;
        end
    end

    assign wb_data = memwb_q.mem_to_reg ? memwb_q.load_data : memwb_q.alu_result;

    assign bypass.wb_reg_write = memwb_q.reg_write;
    assign bypass.wb_dst       = memwb_q.dst;
    assign bypass.wb_data      = wb_data;

    assign o_halt = halt_q;

endmodule

// ==== src/mips_pkg.sv ====
package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMM_W      = 16;
    localparam int OPCODE_W   = 6;
    localparam int FUNCT_W    = 6;

    localparam logic [OPCODE_W-1:0] OP_RTYPE = 6'd0;
    localparam logic [OPCODE_W-1:0] OP_ADDI  = 6'd8;
    localparam logic [OPCODE_W-1:0] OP_LW    = 6'd35;
    localparam logic [OPCODE_W-1:0] OP_SW    = 6'd43;
    localparam logic [OPCODE_W-1:0] OP_HALT  = 6'd63;

    localparam logic [FUNCT_W-1:0] FN_ADD = 6'd32;
    localparam logic [FUNCT_W-1:0] FN_SUB = 6'd34;
    localparam logic [FUNCT_W-1:0] FN_AND = 6'd36;
    localparam logic [FUNCT_W-1:0] FN_OR  = 6'd37;
    localparam logic [FUNCT_W-1:0] FN_SLT = 6'd42;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_EXMEM,
        FWD_MEMWB
    } fwd_sel_e;

    // ALU class chosen by the control unit
    typedef enum logic [1:0] {
        CLS_ADD,
        CLS_SUB,
        CLS_FUNCT
    } alu_class_e;

    typedef struct packed {
        logic       reg_write;
        logic       mem_to_reg;
        logic       mem_read;
        logic       mem_write;
        logic       alu_src;
        logic       reg_dst;
        logic       halt;
        alu_class_e alu_class;
    } ctrl_t;

    typedef struct packed {
        logic [DATA_W-1:0] instr;
        logic [DATA_W-1:0] pc4;
    } ifid_t;

    typedef struct packed {
        ctrl_t                 ctrl;
        logic [DATA_W-1:0]     rs_val;
        logic [DATA_W-1:0]     rt_val;
        logic [DATA_W-1:0]     imm;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [FUNCT_W-1:0]    funct;
    } idex_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  mem_to_reg;
        logic                  halt;
        logic [DATA_W-1:0]     alu_result;
        logic [DATA_W-1:0]     store_data;
        logic [REG_ADDR_W-1:0] dst;
    } exmem_t;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  halt;
        logic [DATA_W-1:0]     alu_result;
        logic [DATA_W-1:0]     load_data;
        logic [REG_ADDR_W-1:0] dst;
    } memwb_t;

endpackage

// ==== tests/mips_ref_model.svh ====
`ifndef MIPS_REF_MODEL_SVH
`define MIPS_REF_MODEL_SVH

function automatic logic [31:0] enc_r(input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [4:0] rd, input logic [5:0] funct);
    return {mips_pkg::OP_RTYPE, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
endtask

// Sequential interpreter stepping one instruction at a time
function automatic void run_reference();
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] res;
    int          pc;
    bit          done;
    for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
    end
    for (int i = 0; i < DMEM_DEPTH; i++) begin
        ref_mem[i] = '0;
    end
    pc = 0;
    done = 1'b0;
    while (pc < prog_len && !done) begin
        ins = prog[pc];
        a   = ref_regs[ins[25:21]];
        b   = ref_regs[ins[20:16]];
        imm = {{16{ins[15]}}, ins[15:0]};
        case (ins[31:26])
            mips_pkg::OP_RTYPE: begin
                case (ins[5:0])
                    mips_pkg::FN_SUB: res = a - b;
                    mips_pkg::FN_AND: res = a & b;
                    mips_pkg::FN_OR:  res = a | b;
                    mips_pkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:          res = a + b;
                endcase
                ref_regs[ins[15:11]] = res;
            end
            mips_pkg::OP_ADDI: ref_regs[ins[20:16]] = a + imm;
            // Word index wraps at the memory depth
            mips_pkg::OP_LW:   ref_regs[ins[20:16]] = ref_mem[((a + imm) >> 2) % DMEM_DEPTH];
            mips_pkg::OP_SW:   ref_mem[((a + imm) >> 2) % DMEM_DEPTH] = b;
            mips_pkg::OP_HALT: done = 1'b1;
            default: ;
        endcase
        ref_regs[0] = '0;
        pc++;
    end
endfunction

task automatic gen_alu_chain();
    prog_len = 0;
    emit(enc_i(mips_pkg::OP_ADDI, 0, 1, 16'd7));
    emit(enc_i(mips_pkg::OP_ADDI, 1, 2, 16'hfffd));
    emit(enc_r(2, 1, 3, mips_pkg::FN_ADD));
    emit(enc_r(3, 2, 4, mips_pkg::FN_SUB));
    emit(enc_r(4, 3, 5, mips_pkg::FN_AND));
    emit(enc_r(5, 4, 6, mips_pkg::FN_OR));
    emit(enc_r(6, 1, 7, mips_pkg::FN_SLT));
    emit(enc_r(1, 7, 8, mips_pkg::FN_SLT));
    emit(enc_i(mips_pkg::OP_ADDI, 8, 9, 16'h8000));
    emit(enc_r(9, 8, 10, mips_pkg::FN_SLT));
    emit({mips_pkg::OP_HALT, 26'd0});
endtask

task automatic gen_load_store();
    prog_len = 0;
    emit(enc_i(mips_pkg::OP_ADDI, 0, 1, 16'h0055));
    emit(enc_i(mips_pkg::OP_ADDI, 0, 2, 16'hfffd));
    emit(enc_i(mips_pkg::OP_SW, 0, 2, 16'd12));
    emit(enc_i(mips_pkg::OP_SW, 0, 1, 16'd8));
    emit(enc_i(mips_pkg::OP_LW, 0, 3, 16'd8));
    emit(enc_r(3, 2, 4, mips_pkg::FN_ADD));
    emit(enc_i(mips_pkg::OP_LW, 0, 5, 16'd12));
    emit(enc_i(mips_pkg::OP_SW, 0, 5, 16'd20));
    emit(enc_i(mips_pkg::OP_LW, 0, 6, 16'd20));
    emit(enc_i(mips_pkg::OP_ADDI, 6, 7, 16'd1));
    emit(enc_i(mips_pkg::OP_SW, 0, 7, 16'd60));
    emit(enc_i(mips_pkg::OP_SW, 0, 1, 16'd4));
    // Address past the end wraps onto word 1
    emit(enc_i(mips_pkg::OP_LW, 0, 8, 16'd68));
    emit({mips_pkg::OP_HALT, 26'd0});
endtask

task automatic gen_zero_reg();
    prog_len = 0;
    emit(enc_i(mips_pkg::OP_ADDI, 0, 0, 16'd5));
    emit(enc_i(mips_pkg::OP_ADDI, 0, 1, 16'd3));
    emit(enc_r(1, 1, 0, mips_pkg::FN_ADD));
    emit(enc_r(0, 1, 2, mips_pkg::FN_ADD));
    emit(enc_i(mips_pkg::OP_SW, 0, 1, 16'd4));
    emit(enc_i(mips_pkg::OP_LW, 0, 0, 16'd4));
    emit(enc_r(0, 0, 3, mips_pkg::FN_ADD));
    emit(enc_r(0, 1, 4, mips_pkg::FN_ADD));
    emit({mips_pkg::OP_HALT, 26'd0});
endtask

task automatic gen_random(input int count);
    logic [31:0] r;
    logic [15:0] imm;
    logic [15:0] offs;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    prog_len = 0;
    for (int i = 0; i < count; i++) begin
        r    = $random(seed);
        imm  = {{8{r[31]}}, r[31:24]};
        offs = {10'd0, r[15:12], 2'b00};
        rs   = {2'b00, r[5:3]};
        rt   = {2'b00, r[8:6]};
        rd   = {2'b00, r[11:9]};
        case (r[2:0])
            3'd0: emit(enc_r(rs, rt, rd, mips_pkg::FN_ADD));
            3'd1: emit(enc_r(rs, rt, rd, mips_pkg::FN_SUB));
            3'd2: emit(enc_r(rs, rt, rd, mips_pkg::FN_AND));
            3'd3: emit(enc_r(rs, rt, rd, mips_pkg::FN_OR));
            3'd4: emit(enc_r(rs, rt, rd, mips_pkg::FN_SLT));
            3'd5: emit(enc_i(mips_pkg::OP_ADDI, rs, rt, imm));
            3'd6: emit(enc_i(mips_pkg::OP_LW, 0, rt, offs));
            default: emit(enc_i(mips_pkg::OP_SW, 0, rt, offs));
        endcase
    end
    emit({mips_pkg::OP_HALT, 26'd0});
endtask

`endif

// ==== tests/tb_mips_core.sv ====
module tb_mips_core;

    localparam int IMEM_DEPTH      = 64;
    localparam int DMEM_DEPTH      = 16;
    localparam int IMEM_AW         = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW         = $clog2(DMEM_DEPTH);
    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 10;
    localparam int N_TESTS         = 6;
    localparam int HALT_LIMIT      = IMEM_DEPTH * 2;
    localparam int WATCHDOG_CYCLES = N_TESTS * (IMEM_DEPTH * 3 + 40);

    logic                            clk;
    logic                            arst_n;
    logic                            run;
    logic                            imem_we;
    logic [IMEM_AW-1:0]              imem_addr;
    logic [mips_pkg::DATA_W-1:0]     imem_data;
    logic [mips_pkg::REG_ADDR_W-1:0] dbg_reg_addr;
    logic [DMEM_AW-1:0]              dbg_mem_addr;
    logic [mips_pkg::DATA_W-1:0]     pc;
    logic [mips_pkg::DATA_W-1:0]     dbg_reg_data;
    logic [mips_pkg::DATA_W-1:0]     dbg_mem_data;
    logic                            halt;

    logic [31:0] prog [IMEM_DEPTH];
    int          prog_len;
    logic [31:0] ref_regs [32];
    logic [31:0] ref_mem [DMEM_DEPTH];
    integer      seed = 32'hcbe08b9d;
    logic        sweeping;
    logic        sweep_mem;
    int          test_errors = 0;
    int          mismatches = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    `include "mips_ref_model.svh"

    mips_core #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) mips_core_inst (
        .i_clk          (clk),
        .i_arst_n       (arst_n),
        .i_run          (run),
        .i_imem_we      (imem_we),
        .i_imem_addr    (imem_addr),
        .i_imem_data    (imem_data),
        .i_dbg_reg_addr (dbg_reg_addr),
        .i_dbg_mem_addr (dbg_mem_addr),
        .o_pc           (pc),
        .o_dbg_reg_data (dbg_reg_data),
        .o_dbg_mem_data (dbg_mem_data),
        .o_halt         (halt)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            test_errors++;
            mismatches++;
        end
    endtask

    // Debug ports are combinational, so sample mid-cycle
    always @(negedge clk) begin
        if (sweeping) begin
            check($sformatf("o_dbg_reg_data[%0d]", dbg_reg_addr), dbg_reg_data,
                  ref_regs[dbg_reg_addr]);
            if (sweep_mem) begin
                check($sformatf("o_dbg_mem_data[%0d]", dbg_mem_addr), dbg_mem_data,
                      ref_mem[dbg_mem_addr]);
            end
        end
    end

    task automatic apply_reset();
        @(posedge clk);
        arst_n  <= 1'b0;
        run     <= 1'b0;
        imem_we <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            imem_we   <= 1'b1;
            imem_addr <= IMEM_AW'(i);
            imem_data <= prog[i];
        end
        @(posedge clk);
        imem_we <= 1'b0;
        run     <= 1'b1;
    endtask

    task automatic sweep_state();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            dbg_reg_addr <= mips_pkg::REG_ADDR_W'(i);
            dbg_mem_addr <= DMEM_AW'(i);
            sweep_mem    <= (i < DMEM_DEPTH);
            sweeping     <= 1'b1;
        end
        @(posedge clk);
        sweeping <= 1'b0;
        @(negedge clk);
    endtask

    task automatic run_test(input string name);
        int cycles;
        test_errors = 0;
        apply_reset();
        check("o_pc", pc, 32'd0);
        check("o_halt", {31'd0, halt}, 32'd0);
        load_program();
        cycles = 0;
        while (!halt && cycles < HALT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!halt) begin
            $display("%s: core did not halt within %0d cycles", name, HALT_LIMIT);
            test_errors++;
        end
        run_reference();
        sweep_state();
        // Halt must still be held
        check("o_halt", {31'd0, halt}, 32'd1);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        arst_n       <= 1'b0;
        run          <= 1'b0;
        imem_we      <= 1'b0;
        imem_addr    <= '0;
        imem_data    <= '0;
        dbg_reg_addr <= '0;
        dbg_mem_addr <= '0;
        sweeping     <= 1'b0;
        sweep_mem    <= 1'b0;
        gen_alu_chain();
        run_test("alu_chain");
        gen_load_store();
        run_test("load_store");
        gen_zero_reg();
        run_test("zero_reg");
        for (int t = 0; t < 3; t++) begin
            gen_random(40);
            run_test($sformatf("random_%0d", t));
        end
        $display("tests: %0d, failing tests: %0d, mismatches: %0d",
                 tests_run, tests_failed, mismatches);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule
